/* include/l1c_settings.svh */
`ifndef L1C_SETTINGS_SVH
`define L1C_SETTINGS_SVH

// address and core word
`define L1C_ADDR_W 32
`define L1C_WORD_W 32

// cache geometry, 64 lines of 16 bytes
`define L1C_LINES 64
`define L1C_IDX_W 6
`define L1C_TAG_W 22
`define L1C_BLK_WORDS 4
`define L1C_BLK_W 128

// requests the memory side can hold at once
`define L1C_MEM_CREDITS 2

`endif

/* verilog/l1c_pkg.sv */
`include "l1c_settings.svh"

package l1c_pkg;

    localparam int WOFF_W = $clog2(`L1C_BLK_WORDS);
    localparam int BOFF_W = $clog2(`L1C_WORD_W / 8);

    // tag | index | word in block | byte in word
    typedef struct packed {
        logic [`L1C_TAG_W-1:0] tag;
        logic [`L1C_IDX_W-1:0] idx;
        logic [WOFF_W-1:0]     word;
        logic [BOFF_W-1:0]     boff;
    } addr_fields_t;

    typedef union packed {
        logic [`L1C_ADDR_W-1:0] flat;
        addr_fields_t           f;
    } cache_addr_u;

    typedef struct packed {
        logic                     wr;
        cache_addr_u              addr;
        logic [`L1C_WORD_W-1:0]   wdata;
        logic [`L1C_WORD_W/8-1:0] strb;
    } core_req_t;

    // reads are always a four beat block burst
    typedef struct packed {
        logic                     wr;
        logic [`L1C_ADDR_W-1:0]   addr;
        logic [`L1C_WORD_W-1:0]   wdata;
        logic [`L1C_WORD_W/8-1:0] strb;
    } mem_req_t;

    typedef struct packed {
        logic [`L1C_WORD_W-1:0] data;
        logic                   last;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CMP,
        ST_REQ,
        ST_REFILL,
        ST_STORE
    } ctrl_state_e;

endpackage

/* verilog/data_store.sv */
`include "l1c_settings.svh"

module data_store (
    input  logic                    clk,
    input  logic                    data_en,
    input  logic                    data_we,
    input  logic [`L1C_IDX_W-1:0]   line_idx,
    input  logic [`L1C_BLK_W/8-1:0] data_strb,
    input  logic [`L1C_BLK_W-1:0]   data_wr,
    output logic [`L1C_BLK_W-1:0]   data_rd
);

    logic [`L1C_BLK_W-1:0] blocks [`L1C_LINES];

    // byte lanes, read returns the old block on a write
    always_ff @(posedge clk) begin
        if (data_en) begin
            if (data_we) begin
                for (int b = 0; b < `L1C_BLK_W / 8; b++) begin
                    if (data_strb[b])
                        blocks[line_idx][b*8 +: 8] <= data_wr[b*8 +: 8];
                end
            end
            data_rd <= blocks[line_idx];
        end
    end

endmodule

/* verilog/tag_store.sv */
`include "l1c_settings.svh"

module tag_store (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  tag_en,
    input  logic                  tag_we,
    input  logic [`L1C_IDX_W-1:0] line_idx,
    input  logic [`L1C_TAG_W-1:0] fill_tag,
    input  logic                  fill_valid,
    input  logic                  flush,
    input  logic                  snp_clear,
    input  logic [`L1C_IDX_W-1:0] snp_idx,
    output logic [`L1C_TAG_W-1:0] tag_rd,
    output logic                  valid_rd
);

    logic [`L1C_TAG_W-1:0] tags [`L1C_LINES];
    logic [`L1C_LINES-1:0] valid;

    always_ff @(posedge clk) begin
        if (tag_en) begin
            if (tag_we)
                tags[line_idx] <= fill_tag;
            tag_rd <= tags[line_idx];
        end
    end

    // refill is applied last so it wins over a snoop clear
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else begin
            if (snp_clear)
                valid[snp_idx] <= 1'b0;
            if (tag_en && tag_we)
                valid[line_idx] <= fill_valid;
        end
    end

    // see a clear landing on this same edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            valid_rd <= 1'b0;
        else if (tag_en)
            valid_rd <= valid[line_idx] && !flush && !(snp_clear && snp_idx == line_idx);
    end

endmodule

/* verilog/snoop_filter.sv */
`include "l1c_settings.svh"

module snoop_filter (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  snp_valid,
    input  l1c_pkg::cache_addr_u  snp_addr,
    output logic                  snp_ready,
    input  logic                  tag_we,
    input  logic [`L1C_IDX_W-1:0] line_idx,
    input  logic [`L1C_TAG_W-1:0] fill_tag,
    input  logic                  refill_active,
    input  l1c_pkg::cache_addr_u  refill_addr,
    output logic                  snp_clear,
    output logic [`L1C_IDX_W-1:0] snp_idx,
    output logic                  refill_guard
);

    import l1c_pkg::*;

    logic [`L1C_TAG_W-1:0] dup_tags [`L1C_LINES];
    logic [`L1C_TAG_W-1:0] dup_rd;
    logic                  snp_take;
    logic                  s1_valid;
    cache_addr_u           s1_addr;
    logic                  same_blk;

    // the duplicate port is busy while a refill writes its tag
    assign snp_ready = !tag_we;
    assign snp_take  = snp_valid && snp_ready;
    assign same_blk  = {snp_addr.f.tag, snp_addr.f.idx} ==
                       {refill_addr.f.tag, refill_addr.f.idx};

    always_ff @(posedge clk) begin
        if (tag_we)
            dup_tags[line_idx] <= fill_tag;
        else if (snp_take)
            dup_rd <= dup_tags[snp_addr.f.idx];
        if (snp_take)
            s1_addr <= snp_addr;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            s1_valid <= 1'b0;
        else
            s1_valid <= snp_take;
    end

    assign snp_clear = s1_valid && (dup_rd == s1_addr.f.tag);
    assign snp_idx   = s1_addr.f.idx;

    // a refill hit by a snoop must not come back valid
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            refill_guard <= 1'b0;
        else if (!refill_active)
            refill_guard <= 1'b0;
        else if (snp_take && same_blk)
            refill_guard <= 1'b1;
    end

endmodule

/* verilog/mem_port.sv */
`include "l1c_settings.svh"

module mem_port (
    input  logic              clk,
    input  logic              rstn,
    input  logic              mem_issue,
    input  l1c_pkg::mem_req_t mem_issue_req,
    input  logic              mem_credit,
    output logic              mem_sent,
    output logic              mem_req_valid,
    output l1c_pkg::mem_req_t mem_req
);

    import l1c_pkg::*;

    localparam int CNT_W = $clog2(`L1C_MEM_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             has_credit;
    logic             pend_q;
    mem_req_t         pend_req;

    assign has_credit    = (credits != '0);
    assign mem_req_valid = (mem_issue || pend_q) && has_credit;
    assign mem_req       = pend_q ? pend_req : mem_issue_req;
    assign mem_sent      = mem_req_valid;

    // request waits here until a credit comes back
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            pend_q <= 1'b0;
        else if (mem_issue && !has_credit)
            pend_q <= 1'b1;
        else if (mem_sent)
            pend_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (mem_issue)
            pend_req <= mem_issue_req;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            credits <= CNT_W'(`L1C_MEM_CREDITS);
        else if (mem_sent && !mem_credit)
            credits <= credits - CNT_W'(1);
        else if (!mem_sent && mem_credit)
            credits <= credits + CNT_W'(1);
    end

endmodule

/* verilog/cache_ctrl.sv */
`include "l1c_settings.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    core_valid,
    input  l1c_pkg::core_req_t      core_req,
    output logic                    core_busy,
    output logic                    core_ack,
    output logic [`L1C_WORD_W-1:0]  core_rdata,
    output logic                    tag_en,
    output logic                    tag_we,
    input  logic [`L1C_TAG_W-1:0]   tag_rd,
    input  logic                    valid_rd,
    output logic                    data_en,
    output logic                    data_we,
    output logic [`L1C_BLK_W/8-1:0] data_strb,
    output logic [`L1C_BLK_W-1:0]   data_wr,
    input  logic [`L1C_BLK_W-1:0]   data_rd,
    output logic [`L1C_IDX_W-1:0]   line_idx,
    output logic [`L1C_TAG_W-1:0]   fill_tag,
    output logic                    fill_valid,
    output logic                    refill_active,
    input  logic                    refill_guard,
    output logic                    mem_issue,
    output l1c_pkg::mem_req_t       mem_issue_req,
    input  logic                    mem_sent,
    input  logic                    mem_rsp_valid,
    input  l1c_pkg::mem_rsp_t       mem_rsp
);

    import l1c_pkg::*;

    localparam int WBYTES = `L1C_WORD_W / 8;

    ctrl_state_e            state;
    ctrl_state_e            state_nx;
    core_req_t              req_q;
    logic                   accept;
    logic                   hit;
    logic                   fill_beat;
    logic                   fill_last;
    logic [WOFF_W-1:0]      beat;
    logic                   ack_q;
    logic                   issue_q;
    logic [`L1C_WORD_W-1:0] rdata_q;
    logic [`L1C_WORD_W-1:0] hit_word;

    // a store is answered as soon as its write leaves
    assign core_ack   = ack_q || (state == ST_STORE && mem_sent);
    assign core_busy  = (state != ST_IDLE) && !core_ack;
    assign core_rdata = rdata_q;
    assign accept     = core_valid && !core_busy;

    assign hit       = valid_rd && (tag_rd == req_q.addr.f.tag);
    assign hit_word  = data_rd[req_q.addr.f.word * `L1C_WORD_W +: `L1C_WORD_W];
    assign fill_beat = (state == ST_REFILL) && mem_rsp_valid;
    assign fill_last = fill_beat && mem_rsp.last;

    assign line_idx      = accept ? core_req.addr.f.idx : req_q.addr.f.idx;
    assign fill_tag      = req_q.addr.f.tag;
    assign fill_valid    = !refill_guard;
    assign refill_active = !req_q.wr &&
                           (state == ST_CMP || state == ST_REQ || state == ST_REFILL);
    assign mem_issue     = issue_q;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE: begin
                if (accept)
                    state_nx = ST_CMP;
            end
            ST_CMP: begin
                if (req_q.wr)
                    state_nx = ST_STORE;
                else if (hit)
                    state_nx = ST_IDLE;
                else
                    state_nx = ST_REQ;
            end
            ST_REQ: begin
                if (mem_sent)
                    state_nx = ST_REFILL;
            end
            ST_REFILL: begin
                if (fill_last)
                    state_nx = ST_IDLE;
            end
            ST_STORE: begin
                // next request may be taken in the ack cycle
                if (mem_sent)
                    state_nx = accept ? ST_CMP : ST_IDLE;
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    always_comb begin
        tag_en    = accept;
        tag_we    = 1'b0;
        data_en   = accept;
        data_we   = 1'b0;
        data_strb = '0;
        data_wr   = {`L1C_BLK_WORDS{req_q.wdata}};
        if (fill_beat) begin
            data_en   = 1'b1;
            data_we   = 1'b1;
            data_strb = {{(`L1C_BLK_W/8 - WBYTES){1'b0}}, {WBYTES{1'b1}}} << (beat * WBYTES);
            data_wr   = {`L1C_BLK_WORDS{mem_rsp.data}};
            tag_en    = fill_last;
            tag_we    = fill_last;
        end else if (state == ST_CMP && req_q.wr && hit) begin
            // store hit merges into the cached copy
            data_en   = 1'b1;
            data_we   = 1'b1;
            data_strb = {{(`L1C_BLK_W/8 - WBYTES){1'b0}}, req_q.strb}
                        << (req_q.addr.f.word * WBYTES);
        end
    end

    always_comb begin
        mem_issue_req       = '0;
        mem_issue_req.wr    = req_q.wr;
        mem_issue_req.wdata = req_q.wdata;
        mem_issue_req.strb  = req_q.strb;
        if (req_q.wr)
            mem_issue_req.addr = {req_q.addr.flat[`L1C_ADDR_W-1:BOFF_W], {BOFF_W{1'b0}}};
        else
            mem_issue_req.addr = {req_q.addr.f.tag, req_q.addr.f.idx,
                                  {(WOFF_W + BOFF_W){1'b0}}};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= ST_IDLE;
            ack_q   <= 1'b0;
            issue_q <= 1'b0;
            beat    <= '0;
        end else begin
            state   <= state_nx;
            ack_q   <= (state == ST_CMP && !req_q.wr && hit) || fill_last;
            issue_q <= (state == ST_CMP) && (req_q.wr || !hit);
            if (state == ST_REQ)
                beat <= '0;
            else if (fill_beat)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= core_req;
        if (state == ST_CMP && !req_q.wr && hit)
            rdata_q <= hit_word;
        else if (fill_beat && beat == req_q.addr.f.word)
            rdata_q <= mem_rsp.data;
    end

endmodule

/* verilog/l1c_top.sv */
`include "l1c_settings.svh"

module l1c_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   core_valid,
    input  l1c_pkg::core_req_t     core_req,
    input  logic                   core_flush,
    output logic                   core_busy,
    output logic                   core_ack,
    output logic [`L1C_WORD_W-1:0] core_rdata,
    input  logic                   snp_valid,
    input  l1c_pkg::cache_addr_u   snp_addr,
    output logic                   snp_ready,
    input  logic                   mem_credit,
    output logic                   mem_req_valid,
    output l1c_pkg::mem_req_t      mem_req,
    input  logic                   mem_rsp_valid,
    input  l1c_pkg::mem_rsp_t      mem_rsp
);

    import l1c_pkg::*;

    logic                   tag_en;
    logic                   tag_we;
    logic [`L1C_TAG_W-1:0]  tag_rd;
    logic                   valid_rd;
    logic                   data_en;
    logic                   data_we;
    logic [`L1C_BLK_W/8-1:0] data_strb;
    logic [`L1C_BLK_W-1:0]  data_wr;
    logic [`L1C_BLK_W-1:0]  data_rd;
    logic [`L1C_IDX_W-1:0]  line_idx;
    logic [`L1C_TAG_W-1:0]  fill_tag;
    logic                   fill_valid;
    logic                   refill_active;
    logic                   refill_guard;
    logic                   snp_clear;
    logic [`L1C_IDX_W-1:0]  snp_idx;
    logic                   mem_issue;
    mem_req_t               mem_issue_req;
    logic                   mem_sent;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .core_valid    (core_valid),
        .core_req      (core_req),
        .core_busy     (core_busy),
        .core_ack      (core_ack),
        .core_rdata    (core_rdata),
        .tag_en        (tag_en),
        .tag_we        (tag_we),
        .tag_rd        (tag_rd),
        .valid_rd      (valid_rd),
        .data_en       (data_en),
        .data_we       (data_we),
        .data_strb     (data_strb),
        .data_wr       (data_wr),
        .data_rd       (data_rd),
        .line_idx      (line_idx),
        .fill_tag      (fill_tag),
        .fill_valid    (fill_valid),
        .refill_active (refill_active),
        .refill_guard  (refill_guard),
        .mem_issue     (mem_issue),
        .mem_issue_req (mem_issue_req),
        .mem_sent      (mem_sent),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    tag_store u_tags (
        .clk        (clk),
        .rstn       (rstn),
        .tag_en     (tag_en),
        .tag_we     (tag_we),
        .line_idx   (line_idx),
        .fill_tag   (fill_tag),
        .fill_valid (fill_valid),
        .flush      (core_flush),
        .snp_clear  (snp_clear),
        .snp_idx    (snp_idx),
        .tag_rd     (tag_rd),
        .valid_rd   (valid_rd)
    );

    data_store u_data (
        .clk       (clk),
        .data_en   (data_en),
        .data_we   (data_we),
        .line_idx  (line_idx),
        .data_strb (data_strb),
        .data_wr   (data_wr),
        .data_rd   (data_rd)
    );

    // the pending read request carries the block being refilled
    snoop_filter u_snoop (
        .clk           (clk),
        .rstn          (rstn),
        .snp_valid     (snp_valid),
        .snp_addr      (snp_addr),
        .snp_ready     (snp_ready),
        .tag_we        (tag_we),
        .line_idx      (line_idx),
        .fill_tag      (fill_tag),
        .refill_active (refill_active),
        .refill_addr   (mem_issue_req.addr),
        .snp_clear     (snp_clear),
        .snp_idx       (snp_idx),
        .refill_guard  (refill_guard)
    );

    mem_port u_mem (
        .clk           (clk),
        .rstn          (rstn),
        .mem_issue     (mem_issue),
        .mem_issue_req (mem_issue_req),
        .mem_credit    (mem_credit),
        .mem_sent      (mem_sent),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

endmodule

/* testbench/mem_model.sv */
`include "l1c_settings.svh"

module mem_model (
    input  logic              clk,
    input  logic              rstn,
    input  logic              hold_credits,
    input  logic              req_valid,
    input  l1c_pkg::mem_req_t req,
    output logic              credit,
    output logic              rsp_valid,
    output l1c_pkg::mem_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    import l1c_pkg::*;

    logic [31:0] mem [logic [29:0]];
    int          read_count = 0;
    bit          overflow = 1'b0;
    int          outstanding = 0;
    longint      cycle = 0;
    longint      credit_due [$];
    longint      burst_due [$];
    logic [29:0] burst_base [$];
    logic [29:0] cur_base;
    logic [29:0] wkey;
    logic [31:0] word;
    int          beat = 0;
    bit          in_burst = 1'b0;
    bit          next_credit;
    bit          next_valid;
    bit          next_last;
    logic [31:0] next_data;

    task automatic poke(logic [31:0] addr, logic [31:0] data);
        mem[addr[31:2]] = data;
    endtask

    function automatic logic [31:0] peek(logic [31:0] addr);
        return mem[addr[31:2]];
    endfunction

    initial begin
        credit    = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
    end

    always @(posedge clk) begin
        if (rstn) begin
            cycle++;
            if (req_valid) begin
                outstanding++;
                if (outstanding > `L1C_MEM_CREDITS && !overflow) begin
                    $display("memory holds %0d requests, more than its credits allow",
                             outstanding);
                    overflow = 1'b1;
                end
                credit_due.push_back(cycle + longint'($urandom_range(0, 5)));
                wkey = req.addr[31:2];
                if (req.wr) begin
                    word = mem[wkey];
                    for (int b = 0; b < 4; b++) begin
                        if (req.strb[b])
                            word[b*8 +: 8] = req.wdata[b*8 +: 8];
                    end
                    mem[wkey] = word;
                end else begin
                    read_count++;
                    burst_due.push_back(cycle + longint'($urandom_range(1, 4)));
                    burst_base.push_back(wkey);
                end
            end
            // pulse of the last cycle is now seen by the cache
            if (credit)
                outstanding--;
            next_credit = !hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle;
            if (next_credit)
                void'(credit_due.pop_front());
            next_valid = 1'b0;
            next_last  = 1'b0;
            next_data  = '0;
            if (!in_burst && burst_due.size() > 0 && burst_due[0] <= cycle) begin
                in_burst = 1'b1;
                beat     = 0;
                cur_base = burst_base.pop_front();
                void'(burst_due.pop_front());
            end
            if (in_burst) begin
                next_valid = 1'b1;
                next_data  = mem[cur_base + 30'(beat)];
                next_last  = (beat == 3);
                beat++;
                if (beat == 4)
                    in_burst = 1'b0;
            end
            #10;
            credit    = next_credit;
            rsp_valid = next_valid;
            rsp.data  = next_data;
            rsp.last  = next_last;
        end
    end

endmodule

/* testbench/tb_l1c.sv */
`include "l1c_settings.svh"

module tb_l1c;
    timeunit 1ns;
    timeprecision 100ps;

    import l1c_pkg::*;

    localparam int N_OPS = 400;
    localparam logic [`L1C_TAG_W-1:0] TAG0 = 22'h01a2b;
    localparam logic [`L1C_TAG_W-1:0] TAG1 = 22'h3c4d5;

    logic                   clk;
    logic                   rstn;
    logic                   core_valid;
    logic                   core_flush;
    logic                   core_busy;
    logic                   core_ack;
    logic [`L1C_WORD_W-1:0] core_rdata;
    core_req_t              core_req;
    logic                   snp_valid;
    logic                   snp_ready;
    cache_addr_u            snp_addr;
    logic                   mem_credit;
    logic                   mem_req_valid;
    mem_req_t               mem_req;
    logic                   mem_rsp_valid;
    mem_rsp_t               mem_rsp;
    logic                   hold;

    logic [31:0] ref_mem [64];
    bit          m_valid [8];
    bit          m_tag [8];
    bit          snooped [8];
    string       names [6] = '{"read_data", "hit_miss", "write_through",
                               "snoop_invalidate", "flush", "credits"};
    int          checks [6];
    int          errors [6];

    l1c_top dut (
        .clk(clk), .rstn(rstn), .core_valid(core_valid), .core_req(core_req),
        .core_flush(core_flush), .core_busy(core_busy), .core_ack(core_ack),
        .core_rdata(core_rdata), .snp_valid(snp_valid), .snp_addr(snp_addr),
        .snp_ready(snp_ready), .mem_credit(mem_credit), .mem_req_valid(mem_req_valid),
        .mem_req(mem_req), .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp)
    );

    mem_model mm (
        .clk(clk), .rstn(rstn), .hold_credits(hold), .req_valid(mem_req_valid),
        .req(mem_req), .credit(mem_credit), .rsp_valid(mem_rsp_valid), .rsp(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(N_OPS * 40 * 100);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] make_addr(bit ts, int idx, int w);
        return {(ts ? TAG1 : TAG0), 6'(idx), 2'(w), 2'b00};
    endfunction

    function automatic int key(bit ts, int idx, int w);
        return int'(ts) * 32 + idx * 4 + w;
    endfunction

    task automatic check_eq(int t, logic [31:0] exp, logic [31:0] act);
        checks[t]++;
        assert (act == exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", names[t], exp, act);
            errors[t]++;
        end
    endtask

    task automatic check_true(int t, bit cond, string what);
        checks[t]++;
        assert (cond) else begin
            $display("%s: %s", names[t], what);
            errors[t]++;
        end
    endtask

    // called and returning 10 ns after a rising edge
    task automatic core_op(int t, logic wr, logic [31:0] a, logic [31:0] wd,
                           logic [3:0] strb, output logic [31:0] rd, output int lat,
                           output bit ok);
        bit acc;
        bit busy_ok;
        bit ready_ok;
        core_req.wr        = wr;
        core_req.addr.flat = a;
        core_req.wdata     = wd;
        core_req.strb      = strb;
        core_valid         = 1'b1;
        do begin
            @(negedge clk);
            acc = !core_busy;
            @(posedge clk);
            #10;
        end while (!acc);
        core_valid = 1'b0;
        lat      = 0;
        ok       = 1'b0;
        rd       = '0;
        busy_ok  = 1'b1;
        ready_ok = 1'b1;
        while (!ok && lat < 200) begin
            @(negedge clk);
            lat++;
            // only the refill tag write blocks snoops
            if (snp_ready != !(mem_rsp_valid && mem_rsp.last))
                ready_ok = 1'b0;
            if (core_ack) begin
                ok = 1'b1;
                rd = core_rdata;
            end else if (!core_busy) begin
                busy_ok = 1'b0;
            end
        end
        @(posedge clk);
        #10;
        check_true(t, busy_ok, $sformatf("core_busy went low before the ack for %h", a));
        check_true(t, ready_ok, $sformatf("snp_ready was wrong during the access to %h", a));
    endtask

    task automatic snoop_op(logic [31:0] a);
        bit acc;
        snp_addr.flat = a;
        snp_valid     = 1'b1;
        do begin
            @(negedge clk);
            acc = snp_ready;
            @(posedge clk);
            #10;
        end while (!acc);
        snp_valid = 1'b0;
        // valid clear lands two edges after acceptance
        repeat (2) @(posedge clk);
        #10;
    endtask

    task automatic do_read(bit ts, int idx, int w, int dt, int ct, bit snp_during);
        logic [31:0] a;
        logic [31:0] got;
        logic [31:0] exp;
        int          lat;
        int          cnt0;
        bit          ok;
        bit          hit;
        a    = make_addr(ts, idx, w);
        hit  = m_valid[idx] && m_tag[idx] == ts;
        exp  = ref_mem[key(ts, idx, w)];
        cnt0 = mm.read_count;
        if (dt == 0 && snooped[idx] && m_tag[idx] == ts) begin
            dt = 3;
            ct = 3;
        end
        if (snp_during && !hit) begin
            fork
                core_op(ct, 1'b0, a, '0, '0, got, lat, ok);
                begin
                    repeat (2) @(posedge clk);
                    #10;
                    snoop_op(a);
                end
            join
        end else begin
            core_op(ct, 1'b0, a, '0, '0, got, lat, ok);
        end
        check_true(ct, ok, $sformatf("read of %h got no ack", a));
        check_eq(dt, exp, got);
        check_eq(ct, hit ? 32'd0 : 32'd1, 32'(mm.read_count - cnt0));
        if (hit)
            check_eq(ct, 32'd2, 32'(lat));
        if (!hit) begin
            m_valid[idx] = !snp_during;
            m_tag[idx]   = ts;
        end
        snooped[idx] = snp_during && !hit;
    endtask

    task automatic do_store(bit ts, int idx, int w, int t);
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] got;
        logic [3:0]  strb;
        int          lat;
        int          k;
        bit          ok;
        a    = make_addr(ts, idx, w);
        wd   = $urandom;
        strb = 4'($urandom_range(0, 15));
        k    = key(ts, idx, w);
        core_op(t, 1'b1, a, wd, strb, got, lat, ok);
        check_true(t, ok, $sformatf("store to %h got no ack", a));
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                ref_mem[k][b*8 +: 8] = wd[b*8 +: 8];
        end
        // write reached memory on the edge after the ack
        check_eq(t, ref_mem[k], mm.peek(a));
    endtask

    task automatic change_and_snoop(bit ts, int idx, int w);
        logic [31:0] a;
        a = make_addr(ts, idx, w);
        ref_mem[key(ts, idx, w)] = $urandom;
        mm.poke(a, ref_mem[key(ts, idx, w)]);
        snoop_op(a);
        if (m_valid[idx] && m_tag[idx] == ts) begin
            m_valid[idx] = 1'b0;
            snooped[idx] = 1'b1;
        end
    endtask

    task automatic do_flush();
        core_flush = 1'b1;
        @(posedge clk);
        #10;
        core_flush = 1'b0;
        for (int i = 0; i < 8; i++)
            m_valid[i] = 1'b0;
    endtask

    task automatic report(int t);
        $display("test %-16s %0d checks, %0d errors", names[t], checks[t], errors[t]);
    endtask

    initial begin
        logic [31:0] a;
        bit          ts;
        int          idx;
        int          w;
        int          r;
        int          n_chk;
        int          n_err;
        void'($urandom(32'h8dab));
        rstn       = 1'b0;
        core_valid = 1'b0;
        core_req   = '0;
        core_flush = 1'b0;
        snp_valid  = 1'b0;
        snp_addr   = '0;
        hold       = 1'b0;
        for (int i = 0; i < 64; i++) begin
            a = make_addr(i / 32 == 1, (i / 4) % 8, i % 4);
            ref_mem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h3c5a96e1;
            mm.poke(a, ref_mem[i]);
        end
        repeat (8) @(posedge clk);
        #10;
        rstn = 1'b1;
        @(posedge clk);
        #10;

        for (int i = 0; i < N_OPS; i++) begin
            ts  = $urandom_range(0, 1) == 1;
            idx = $urandom_range(0, 7);
            w   = $urandom_range(0, 3);
            r   = $urandom_range(0, 99);
            if (r < 50)
                do_read(ts, idx, w, 0, 1, r < 12);
            else if (r < 80)
                do_store(ts, idx, w, 2);
            else if (r < 98)
                change_and_snoop(ts, idx, w);
            else
                do_flush();
        end
        for (int t = 0; t < 4; t++)
            report(t);

        for (int i = 0; i < 8; i++)
            do_read(1'b0, i, 0, 0, 1, 1'b0);
        do_flush();
        for (int i = 0; i < 8; i++)
            do_read(1'b0, i, 1, 4, 4, 1'b0);
        report(4);

        // starve credits, then let them return
        hold = 1'b1;
        fork
            begin
                do_read(1'b1, 3, 2, 5, 5, 1'b0);
                do_store(1'b1, 3, 1, 5);
                do_read(1'b1, 3, 1, 5, 5, 1'b0);
                do_store(1'b0, 5, 0, 5);
                do_read(1'b0, 5, 0, 5, 5, 1'b0);
            end
            begin
                repeat (40) @(posedge clk);
                #10;
                hold = 1'b0;
            end
        join
        check_true(5, !mm.overflow, "a request was sent without a credit");
        report(5);

        n_chk = 0;
        n_err = 0;
        for (int t = 0; t < 6; t++) begin
            n_chk += checks[t];
            n_err += errors[t];
        end
        $display("total %0d checks, %0d errors", n_chk, n_err);
        if (n_err == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
verilog/l1c_pkg.sv
verilog/data_store.sv
verilog/tag_store.sv
verilog/snoop_filter.sv
verilog/mem_port.sv
verilog/cache_ctrl.sv
verilog/l1c_top.sv
testbench/mem_model.sv
testbench/tb_l1c.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_l1c
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
